//--- compile.f
axis_pkg.sv
frame_pkg.sv
axis_if.sv
frame_checker.sv
frame_fifo.sv
frame_stats.sv
frame_rx_top.sv
tb_frame_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the frame receive testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_frame_rx -f compile.f \
  -o sim_frame_rx > build.log 2>&1 \
  && ./obj_dir/sim_frame_rx > sim.log 2>&1 \
  || echo "build or run stopped early, see build.log and sim.log"

grep -q "Simulation finished: PASS" sim.log 2>/dev/null \
  && { echo "result: pass"; exit 0; } \
  || { echo "result: fail, see sim.log"; exit 1; }

//--- tb_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frame_rx;

  typedef axis_pkg::data_t byte_q_t [$];

  localparam int FATE_GOOD      = 0;
  localparam int FATE_SUM       = 1;  // check byte wrong
  localparam int FATE_LEN       = 2;  // length out of range
  localparam int RANDOM_FRAMES  = 40;
  localparam int TIMEOUT_CYCLES = 20000;  // ample margin over the whole run
  localparam int DRAIN_CYCLES   = 5 * (frame_pkg::FIFO_DEPTH + 1) + 8;  // one beat per 5 cycles
  localparam int OV_LENS [6]    = '{12, 12, 12, 7, 2, 3};  // fills the FIFO to exactly full

  logic                            clk        = 1'b0;
  logic                            rst        = 1'b1;
  axis_pkg::data_t                 in_tdata   = '0;
  logic                            in_tvalid  = 1'b0;
  logic                            in_tready;
  logic                            in_tlast   = 1'b0;
  axis_pkg::data_t                 out_tdata;
  logic                            out_tvalid;
  logic                            out_tready = 1'b0;
  logic                            out_tlast;
  logic                            dropping;
  logic [frame_pkg::CNT_WIDTH-1:0] good_frames;
  logic [frame_pkg::CNT_WIDTH-1:0] bad_frames;
  logic [frame_pkg::CNT_WIDTH-1:0] dropped_frames;

  int              ready_mode  = 0;  // 0 low, 1 high, 2 random stalls
  int              stall_run   = 0;
  logic [31:0]     rng         = 32'd3669;
  logic [31:0]     ready_rng   = 32'd3669;
  axis_pkg::beat_t exp_q [$];
  int              exp_good    = 0;
  int              exp_bad     = 0;
  int              exp_drop    = 0;
  int              errors      = 0;
  int              checks      = 0;
  int              tests       = 0;
  int              cycles      = 0;
  int              drop_cycles = 0;

  frame_rx_top DUT (
    .clk            (clk),
    .rst            (rst),
    .in_tdata       (in_tdata),
    .in_tvalid      (in_tvalid),
    .in_tready      (in_tready),
    .in_tlast       (in_tlast),
    .out_tdata      (out_tdata),
    .out_tvalid     (out_tvalid),
    .out_tready     (out_tready),
    .out_tlast      (out_tlast),
    .dropping       (dropping),
    .good_frames    (good_frames),
    .bad_frames     (bad_frames),
    .dropped_frames (dropped_frames)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic int rand_len();
    int span;
    span = frame_pkg::MAX_FRAME_LEN - frame_pkg::MIN_FRAME_LEN + 1;
    return frame_pkg::MIN_FRAME_LEN + int'(next_rand() % 32'(span));
  endfunction

  // expected fate of a frame from its bytes alone
  function automatic int frame_fate(input byte_q_t f);
    axis_pkg::data_t sum;
    int i;
    sum = '0;
    if (f.size() < frame_pkg::MIN_FRAME_LEN || f.size() > frame_pkg::MAX_FRAME_LEN) begin
      return FATE_LEN;
    end
    for (i = 0; i < f.size() - 1; i++) begin
      sum ^= f[i];
    end
    if (sum != f[f.size() - 1]) begin
      return FATE_SUM;
    end
    return FATE_GOOD;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic build_frame(input int len, input bit corrupt, output byte_q_t f);
    axis_pkg::data_t sum;
    axis_pkg::data_t b;
    int i;
    f.delete();
    sum = '0;
    for (i = 0; i < len - 1; i++) begin
      b = axis_pkg::data_t'(next_rand());
      f.push_back(b);
      sum ^= b;
    end
    if (corrupt) begin
      sum ^= axis_pkg::data_t'(next_rand()) | 8'h01;  // nonzero flip
    end
    f.push_back(sum);
  endtask

  task automatic expect_frame(input byte_q_t f);
    axis_pkg::beat_t b;
    int i;
    for (i = 0; i < f.size(); i++) begin
      b.data = f[i];
      b.last = (i == f.size() - 1);
      exp_q.push_back(b);
    end
  endtask

  task automatic send_frame(input byte_q_t f);
    int i;
    for (i = 0; i < f.size(); i++) begin
      @(negedge clk);
      in_tdata  = f[i];
      in_tvalid = 1'b1;
      in_tlast  = (i == f.size() - 1);
      @(posedge clk);
      while (!in_tready) @(posedge clk);
    end
    @(negedge clk);
    in_tvalid = 1'b0;
    in_tlast  = 1'b0;
  endtask

  task automatic play_frame(input byte_q_t f);
    if (frame_fate(f) == FATE_GOOD) begin
      expect_frame(f);
      exp_good++;
    end else begin
      exp_bad++;
    end
    send_frame(f);
  endtask

  // counters move once per frame, so the sum tells when every frame is decided
  task automatic wait_total();
    while (int'(good_frames) + int'(bad_frames) + int'(dropped_frames)
           != exp_good + exp_bad + exp_drop) begin
      @(posedge clk);
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(posedge clk);
      waited++;
    end
  endtask

  task automatic check_counts();
    check_value(32'(good_frames), exp_good, "good_frames");
    check_value(32'(bad_frames), exp_bad, "bad_frames");
    check_value(32'(dropped_frames), exp_drop, "dropped_frames");
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "FAILED");
  endtask

  always @(negedge clk) begin
    ready_rng = xorshift32(ready_rng);
    if (ready_mode == 2) begin
      if (stall_run < 4 && ready_rng[1:0] == 2'b00) begin
        out_tready = 1'b0;
        stall_run++;
      end else begin
        out_tready = 1'b1;
        stall_run  = 0;
      end
    end else begin
      out_tready = (ready_mode == 1);
      stall_run  = 0;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (dropping) drop_cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timed out after %0d cycles, the DUT stopped making progress", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin : compare
    axis_pkg::beat_t e;
    forever begin
      @(posedge clk);
      if (!rst && out_tvalid && out_tready) begin
        if (exp_q.size() == 0) begin
          $display("unexpected output beat at %0t ns with no good frame waiting", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          check_value(32'(out_tdata), 32'(e.data), "out_tdata");
          check_value(32'(out_tlast), 32'(e.last), "out_tlast");
        end
      end
    end
  end

  initial begin : main
    byte_q_t f;
    int      n;
    int      err0;
    int      used;
    int      drops0;
    int      sent0;
    int      len;
    bit      corrupt;
    bit      fits;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    err0 = errors;
    ready_mode = 1;
    for (n = 0; n < 10; n++) begin
      build_frame(rand_len(), 1'b0, f);
      play_frame(f);
    end
    wait_total();
    wait_drained();
    check_counts();
    end_test("good frames in order", err0);

    err0 = errors;
    for (n = 0; n < 12; n++) begin
      build_frame(rand_len(), n % 3 == 1, f);
      play_frame(f);
    end
    wait_total();
    wait_drained();
    check_counts();
    end_test("bad check byte", err0);

    err0 = errors;
    build_frame(1, 1'b0, f);
    play_frame(f);
    build_frame(frame_pkg::MAX_FRAME_LEN + 1, 1'b0, f);
    play_frame(f);
    build_frame(frame_pkg::MAX_FRAME_LEN, 1'b0, f);
    play_frame(f);
    build_frame(frame_pkg::MIN_FRAME_LEN, 1'b0, f);
    play_frame(f);
    wait_total();
    wait_drained();
    check_counts();
    end_test("length limits", err0);

    err0 = errors;
    ready_mode = 0;
    repeat (2) @(negedge clk);
    used = 0;
    for (n = 0; n < 6; n++) begin
      build_frame(OV_LENS[n], 1'b0, f);
      fits = used + OV_LENS[n] <= frame_pkg::FIFO_DEPTH + 1;  // memory plus output register
      if (fits) begin
        expect_frame(f);
        exp_good++;
        used += OV_LENS[n];
      end else begin
        exp_drop++;
      end
      drops0 = drop_cycles;
      send_frame(f);
      wait_total();
      check_value(32'(drop_cycles != drops0), fits ? 32'd0 : 32'd1, "dropping seen");
      repeat (4) @(negedge clk);
    end
    ready_mode = 1;
    wait_drained();
    check_counts();
    end_test("overflow", err0);

    err0 = errors;
    sent0 = int'(good_frames) + int'(bad_frames);
    ready_mode = 2;
    for (n = 0; n < RANDOM_FRAMES; n++) begin
      len = rand_len();
      corrupt = next_rand() % 32'd5 == 32'd0;
      build_frame(len, corrupt, f);
      play_frame(f);
      repeat (f.size()) @(negedge clk);  // keeps input rate below the drain rate
    end
    wait_total();
    wait_drained();
    check_counts();
    check_value(32'(int'(good_frames) + int'(bad_frames) - sent0), RANDOM_FRAMES,
                "frames counted");
    ready_mode = 1;
    end_test("random with back-pressure", err0);

    if (exp_q.size() != 0) begin
      $display("%0d expected output beats never appeared", exp_q.size());
      errors++;
    end
    $display("tests %0d, checks %0d, errors %0d, good %0d, bad %0d, dropped %0d",
             tests, checks, errors, good_frames, bad_frames, dropped_frames);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- frame_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_rx_top (
  input  logic                            clk,
  input  logic                            rst,
  input  axis_pkg::data_t                 in_tdata,
  input  logic                            in_tvalid,
  output logic                            in_tready,
  input  logic                            in_tlast,
  output axis_pkg::data_t                 out_tdata,
  output logic                            out_tvalid,
  input  logic                            out_tready,
  output logic                            out_tlast,
  output logic                            dropping,
  output logic [frame_pkg::CNT_WIDTH-1:0] good_frames,
  output logic [frame_pkg::CNT_WIDTH-1:0] bad_frames,
  output logic [frame_pkg::CNT_WIDTH-1:0] dropped_frames
);

  axis_if chk_s ();  // checked stream, tuser marks bad frames

  frame_pkg::frame_event_t frame_event;

  frame_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .in_tdata  (in_tdata),
    .in_tvalid (in_tvalid),
    .in_tready (in_tready),
    .in_tlast  (in_tlast),
    .out       (chk_s.source)
  );

  frame_fifo u_fifo (
    .clk         (clk),
    .rst         (rst),
    .in          (chk_s.sink),
    .out_tdata   (out_tdata),
    .out_tvalid  (out_tvalid),
    .out_tready  (out_tready),
    .out_tlast   (out_tlast),
    .dropping    (dropping),
    .frame_event (frame_event)
  );

  frame_stats u_stats (
    .clk            (clk),
    .rst            (rst),
    .frame_event    (frame_event),
    .good_frames    (good_frames),
    .bad_frames     (bad_frames),
    .dropped_frames (dropped_frames)
  );

endmodule

`default_nettype wire

//--- frame_stats.sv
`timescale 1ns/1ps
`default_nettype none

module frame_stats (
  input  logic                             clk,
  input  logic                             rst,
  input  frame_pkg::frame_event_t          frame_event,
  output logic [frame_pkg::CNT_WIDTH-1:0]  good_frames,
  output logic [frame_pkg::CNT_WIDTH-1:0]  bad_frames,
  output logic [frame_pkg::CNT_WIDTH-1:0]  dropped_frames
);

  // count up on hit, hold at all ones
  function automatic logic [frame_pkg::CNT_WIDTH-1:0] bump(
    input logic [frame_pkg::CNT_WIDTH-1:0] cnt,
    input logic                            hit
  );
    if (hit && cnt != '1) begin
      bump = cnt + 1'b1;
    end else begin
      bump = cnt;
    end
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      good_frames    <= '0;
      bad_frames     <= '0;
      dropped_frames <= '0;
    end else begin
      good_frames    <= bump(good_frames, frame_event == frame_pkg::EV_COMMIT);
      bad_frames     <= bump(bad_frames, frame_event == frame_pkg::EV_REJECT);
      dropped_frames <= bump(dropped_frames, frame_event == frame_pkg::EV_OVERFLOW);
    end
  end

endmodule

`default_nettype wire

//--- frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module frame_fifo (
  input  logic                    clk,
  input  logic                    rst,
  axis_if.sink                    in,
  output axis_pkg::data_t         out_tdata,
  output logic                    out_tvalid,
  input  logic                    out_tready,
  output logic                    out_tlast,
  output logic                    dropping,
  output frame_pkg::frame_event_t frame_event
);

  // extra msb tells a full memory from an empty one
  typedef logic [frame_pkg::FIFO_ADDR_WIDTH:0]   ptr_t;
  typedef logic [frame_pkg::FIFO_ADDR_WIDTH-1:0] addr_t;

  axis_pkg::beat_t mem [frame_pkg::FIFO_DEPTH];
  axis_pkg::beat_t out_q;

  ptr_t wr_ptr;      // end of the last committed frame
  ptr_t wr_ptr_cur;  // speculative, inside the frame being written
  ptr_t rd_ptr;
  ptr_t rd_limit;    // committed pointer as seen by the read side

  logic                    out_valid_q;
  logic                    drop_q;
  logic                    mem_full;
  logic                    discard;
  logic                    wr_en;
  logic                    empty;
  logic                    rd_en;
  frame_pkg::frame_event_t event_q;

  // store-and-forward, never back-pressures the checker
  assign in.tready = 1'b1;

  assign mem_full = (wr_ptr_cur - rd_ptr) == ptr_t'(frame_pkg::FIFO_DEPTH);
  assign discard  = in.tvalid & (drop_q | mem_full);
  assign wr_en    = in.tvalid & ~drop_q & ~mem_full;

  // high for the whole overflowing frame, the first discarded beat included
  assign dropping = drop_q | discard;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_q     <= 1'b0;
      event_q    <= frame_pkg::EV_NONE;
    end else begin
      event_q <= frame_pkg::EV_NONE;
      if (discard) begin
        drop_q <= ~in.tlast;
        if (in.tlast) begin
          wr_ptr_cur <= wr_ptr;  // roll back the dropped frame
          event_q    <= frame_pkg::EV_OVERFLOW;
        end
      end else if (wr_en) begin
        wr_ptr_cur <= wr_ptr_cur + 1'b1;
        if (in.tlast) begin
          if (in.tuser) begin
            wr_ptr_cur <= wr_ptr;
            event_q    <= frame_pkg::EV_REJECT;
          end else begin
            wr_ptr  <= wr_ptr_cur + 1'b1;
            event_q <= frame_pkg::EV_COMMIT;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr_t'(wr_ptr_cur)] <= '{last: in.tlast, data: in.tdata};
    end
  end

  // read side only sees whole committed frames
  assign empty = rd_limit == rd_ptr;
  assign rd_en = ~empty & (~out_valid_q | out_tready);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr      <= '0;
      rd_limit    <= '0;
      out_valid_q <= 1'b0;
    end else begin
      rd_limit <= wr_ptr;
      if (rd_en) begin
        rd_ptr      <= rd_ptr + 1'b1;
        out_valid_q <= 1'b1;
      end else if (out_tready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      out_q <= mem[addr_t'(rd_ptr)];
    end
  end

  assign out_tdata   = out_q.data;
  assign out_tlast   = out_q.last;
  assign out_tvalid  = out_valid_q;
  assign frame_event = event_q;

endmodule

`default_nettype wire

//--- frame_checker.sv
`timescale 1ns/1ps
`default_nettype none

module frame_checker (
  input  logic            clk,
  input  logic            rst,
  input  axis_pkg::data_t in_tdata,
  input  logic            in_tvalid,
  output logic            in_tready,
  input  logic            in_tlast,
  axis_if.source          out
);

  typedef logic [frame_pkg::LEN_WIDTH-1:0] len_t;

  axis_pkg::data_t data_q;
  logic            valid_q;
  logic            last_q;
  logic            bad_q;
  axis_pkg::data_t xor_q;  // xor of earlier bytes in this frame
  len_t            cnt_q;  // beats already seen in this frame
  len_t            len;    // length counting the current beat
  logic            accept;
  logic            len_bad;
  logic            sum_bad;

  // one-entry stage, free when empty or being drained
  assign in_tready = ~valid_q | out.tready;
  assign accept    = in_tvalid & in_tready;

  // saturate so that long frames stay above the limit
  assign len = (cnt_q == '1) ? cnt_q : cnt_q + 1'b1;

  assign len_bad = (len < len_t'(frame_pkg::MIN_FRAME_LEN)) |
                   (len > len_t'(frame_pkg::MAX_FRAME_LEN));
  assign sum_bad = in_tdata != xor_q;  // last byte must equal xor of the rest

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      cnt_q   <= '0;
      xor_q   <= '0;
    end else if (accept) begin
      valid_q <= 1'b1;
      if (in_tlast) begin
        cnt_q <= '0;  // next beat starts a new frame
        xor_q <= '0;
      end else begin
        cnt_q <= len;
        xor_q <= xor_q ^ in_tdata;
      end
    end else if (out.tready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      data_q <= in_tdata;
      last_q <= in_tlast;
      bad_q  <= in_tlast & (sum_bad | len_bad);
    end
  end

  assign out.tdata  = data_q;
  assign out.tvalid = valid_q;
  assign out.tlast  = last_q;
  assign out.tuser  = bad_q;

endmodule

`default_nettype wire

//--- axis_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axis_if;

  axis_pkg::data_t tdata;
  logic            tvalid;
  logic            tready;
  logic            tlast;
  logic            tuser;  // frame bad, only meaningful with tlast

  modport source (
    output tdata,
    output tvalid,
    input  tready,
    output tlast,
    output tuser
  );

  modport sink (
    input  tdata,
    input  tvalid,
    output tready,
    input  tlast,
    input  tuser
  );

endinterface

`default_nettype wire

//--- frame_pkg.sv
`default_nettype none

package frame_pkg;

  // frame memory
  localparam int FIFO_ADDR_WIDTH = 5;
  localparam int FIFO_DEPTH      = 1 << FIFO_ADDR_WIDTH;

  // legal frame length in beats, check byte included
  localparam int MIN_FRAME_LEN = 2;
  localparam int MAX_FRAME_LEN = 16;
  localparam int LEN_WIDTH     = 5;  // checker length counter, saturates

  localparam int CNT_WIDTH = 16;  // statistics counters

  // fate of a frame, reported once per frame by the FIFO
  typedef enum logic [1:0] {
    EV_NONE     = 2'd0,
    EV_COMMIT   = 2'd1,
    EV_REJECT   = 2'd2,
    EV_OVERFLOW = 2'd3
  } frame_event_t;

endpackage

`default_nettype wire

//--- axis_pkg.sv
`default_nettype none

package axis_pkg;

  // one byte per beat
  localparam int DATA_WIDTH = 8;

  typedef logic [DATA_WIDTH-1:0] data_t;

  // beat as held in the frame memory and the output register
  typedef struct packed {
    logic  last;
    data_t data;
  } beat_t;

endpackage

`default_nettype wire
